//--- gnn_debug.f
rtl/gnn_debug_pkg.sv
rtl/probe_capture.sv
rtl/stage_monitor.sv
rtl/addr_watch.sv
rtl/debug_readout.sv
rtl/gnn_debug_top.sv
testbench/gnn_debug_props.sv
testbench/gnn_debug_tb.sv

//--- testbench/gnn_debug_trace.txt
# vld rdy wh_addr pe_data pe_strobe feat_ena feat_addr clear watch0 watch1 sel stage expect check
# all hex; expect is debug_o one edge after the line is applied
0 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 1 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 2 3 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 3 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 4 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 5 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 6 0 0000000c 1
0 0 0000 000 0 0 0000 0 0123 02ab 7 0 00000000 1
1 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000000 1
0 8 0000 000 0 0 0000 0 0123 02ab 0 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000080 1
4 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000081 1
0 2 0000 000 0 0 0000 0 0123 02ab 0 0 00000081 1
0 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000089 1
0 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000099 1
0 0 0000 000 0 0 0000 1 0123 02ab 0 0 00000099 1
0 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000099 1
0 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000000 1
2 2 0000 000 0 0 0000 0 0123 02ab 1 1 00000000 1
2 2 0000 000 0 0 0000 0 0123 02ab 1 1 00000000 1
2 0 0000 000 0 0 0000 0 0123 02ab 1 1 00000001 1
2 2 0000 000 0 0 0000 0 0123 02ab 1 1 00000002 1
2 0 0000 000 0 0 0000 0 0123 02ab 2 1 00000001 1
0 0 0000 000 0 0 0000 0 0123 02ab 1 1 00000003 1
0 0 0000 000 0 0 0000 0 0123 02ab 2 1 00000002 1
0 0 0000 000 0 0 0000 0 0123 02ab 1 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 2 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 1 3 00000000 1
0 0 0123 abc 1 0 0000 0 0123 02ab 3 0 00000000 1
0 0 02ab 5a5 1 0 0000 0 0123 02ab 3 0 00000000 1
0 0 0123 fff 0 0 0000 0 0123 02ab 3 0 00000abc 1
0 0 0124 777 1 0 0000 0 0123 02ab 4 0 000005a5 1
0 0 0000 000 0 0 0000 0 0123 02ab 3 0 00000abc 1
0 0 0000 000 0 0 0000 0 0123 02ab 4 0 000005a5 1
0 0 0000 000 0 0 0000 0 0123 02ab 3 0 00000abc 1
0 0 0000 000 0 1 a93f 0 0123 02ab 5 0 00000000 1
0 0 0000 000 0 0 ffff 0 0123 02ab 5 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 5 0 00000001 1
0 0 0000 000 0 1 a940 0 0123 02ab 5 0 00000001 1
0 0 0000 000 0 0 0000 0 0123 02ab 5 0 00000001 1
0 0 0000 000 0 0 0000 0 0123 02ab 5 0 00000003 1
1 1 0000 000 0 0 0000 1 0123 02ab 1 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 1 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 1 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 0 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 5 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 3 0 00000000 1
0 0 0000 000 0 0 0000 0 0123 02ab 6 0 0000000c 1

//--- testbench/gnn_debug_tb.sv
module gnn_debug_tb;

  localparam int    RST_CYCLES = 8;
  localparam int    NUM_FIELDS = 14;
  localparam string TRACE_FILE = "testbench/gnn_debug_trace.txt";

  logic                                  clk;
  logic                                  rst_n;
  logic [gnn_debug_pkg::NUM_STAGES-1:0]  vld_i;
  logic [gnn_debug_pkg::NUM_STAGES-1:0]  rdy_i;
  logic [gnn_debug_pkg::WH_ADDR_W-1:0]   wh_addr_i;
  logic [gnn_debug_pkg::PE_DATA_W-1:0]   pe_data_i;
  logic                                  pe_strobe_i;
  logic                                  feat_ena_i;
  logic [gnn_debug_pkg::FEAT_ADDR_W-1:0] feat_addr_i;
  logic                                  clear_i;
  logic [gnn_debug_pkg::WH_ADDR_W-1:0]   watch_addr0_i;
  logic [gnn_debug_pkg::WH_ADDR_W-1:0]   watch_addr1_i;
  gnn_debug_pkg::debug_sel_e             debug_sel_i;
  gnn_debug_pkg::stage_e                 stage_sel_i;
  logic [gnn_debug_pkg::DBG_W-1:0]       debug_o;

  // fields of the current trace line
  logic [gnn_debug_pkg::NUM_STAGES-1:0]  v_vld;
  logic [gnn_debug_pkg::NUM_STAGES-1:0]  v_rdy;
  logic [gnn_debug_pkg::WH_ADDR_W-1:0]   v_wh;
  logic [gnn_debug_pkg::PE_DATA_W-1:0]   v_pe;
  logic                                  v_str;
  logic                                  v_fe;
  logic [gnn_debug_pkg::FEAT_ADDR_W-1:0] v_fa;
  logic                                  v_clr;
  logic [gnn_debug_pkg::WH_ADDR_W-1:0]   v_wa0;
  logic [gnn_debug_pkg::WH_ADDR_W-1:0]   v_wa1;
  logic [2:0]                            v_sel;
  logic [1:0]                            v_ssel;
  logic [gnn_debug_pkg::DBG_W-1:0]       v_exp;
  logic                                  v_chk;

  string vectors[$];
  int    errors;
  int    checks;
  int    cycles;
  int    cycle_limit;

  gnn_debug_top dut_i (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: run stopped after %0d cycles with %0d errors", cycles, errors);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic int parse_line(input string line);
    return $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   v_vld, v_rdy, v_wh, v_pe, v_str, v_fe, v_fa, v_clr,
                   v_wa0, v_wa1, v_sel, v_ssel, v_exp, v_chk);
  endfunction

  task automatic load_trace();
    int    fd;
    int    lineno;
    int    nf;
    string line;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Trace file %s could not be opened", TRACE_FILE);
      errors++;
      return;
    end
    lineno = 0;
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0)
        break;
      lineno++;
      if (line.len() < 2 || line[0] == "#")
        continue; // blank or column notes
      nf = parse_line(line);
      if (nf != NUM_FIELDS) begin
        $display("Trace line %0d holds %0d of %0d fields", lineno, nf, NUM_FIELDS);
        errors++;
      end else
        vectors.push_back(line);
    end
    $fclose(fd);
    if (vectors.size() == 0) begin
      $display("Trace file %s holds no vectors", TRACE_FILE);
      errors++;
    end
  endtask

  task automatic apply_vector(input string line);
    void'(parse_line(line));
    vld_i         = v_vld;
    rdy_i         = v_rdy;
    wh_addr_i     = v_wh;
    pe_data_i     = v_pe;
    pe_strobe_i   = v_str;
    feat_ena_i    = v_fe;
    feat_addr_i   = v_fa;
    clear_i       = v_clr;
    watch_addr0_i = v_wa0;
    watch_addr1_i = v_wa1;
    debug_sel_i   = gnn_debug_pkg::debug_sel_e'(v_sel);
    stage_sel_i   = gnn_debug_pkg::stage_e'(v_ssel);
  endtask

  task automatic check_output(input int idx);
    if (v_chk) begin
      checks++;
      assert (debug_o === v_exp)
      else begin
        errors++;
        $display("Fail at time %0t: vector %0d debug_o %h expected %h",
                 $time, idx, debug_o, v_exp);
      end
    end
  endtask

  initial begin
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    cycle_limit   = 0;
    rst_n         = 1'b1;
    vld_i         = '0;
    rdy_i         = '0;
    wh_addr_i     = '0;
    pe_data_i     = '0;
    pe_strobe_i   = 1'b0;
    feat_ena_i    = 1'b0;
    feat_addr_i   = '0;
    clear_i       = 1'b0;
    watch_addr0_i = '0;
    watch_addr1_i = '0;
    debug_sel_i   = gnn_debug_pkg::SEL_FLAGS;
    stage_sel_i   = gnn_debug_pkg::STAGE_SPMM;
    load_trace();
    cycle_limit = vectors.size() + 20;
    #1 rst_n = 1'b0; // falling edge after time 0
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (vectors.size() > 0) begin
      apply_vector(vectors[0]);
      for (int i = 1; i <= vectors.size(); i++) begin
        @(posedge clk);
        #1;
        check_output(i - 1); // line i-1 selected its word one edge ago
        if (i < vectors.size())
          apply_vector(vectors[i]);
      end
    end
    errors = errors + dut_i.u_props.fails; // bound property failures
    $display("Summary: %0d vectors, %0d checks, %0d errors", vectors.size(), checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- testbench/gnn_debug_props.sv
module gnn_debug_props (
  input logic                                                          clk,
  input logic                                                          rst_n,
  input logic                                                          clr_q,
  input logic [gnn_debug_pkg::NUM_STAGES-1:0]                          seen_vld,
  input logic [gnn_debug_pkg::NUM_STAGES-1:0]                          seen_rdy,
  input logic [gnn_debug_pkg::NUM_STAGES-1:0][gnn_debug_pkg::CNT_W-1:0] xfer_cnt,
  input logic [gnn_debug_pkg::DBG_W-1:0]                               debug_o
);

  int fails = 0;

  a_reset_zero: assert property (@(posedge clk) !rst_n |-> debug_o == '0)
    else begin
      fails++;
      $error("debug_o not zero during reset");
    end

  // sticky bits only drop on clear
  a_flags_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    !clr_q |=> ((~{seen_vld, seen_rdy} & $past({seen_vld, seen_rdy})) == '0))
    else begin
      fails++;
      $error("sticky flag dropped without clear");
    end

  for (genvar s = 0; s < gnn_debug_pkg::NUM_STAGES; s++) begin : g_xfer
    a_xfer_mono: assert property (@(posedge clk) disable iff (!rst_n)
      !clr_q |=> xfer_cnt[s] >= $past(xfer_cnt[s]))
      else begin
        fails++;
        $error("stage %0d transfer count decreased", s);
      end
  end

endmodule

bind gnn_debug_top gnn_debug_props u_props (
  .clk, .rst_n, .clr_q, .seen_vld, .seen_rdy, .xfer_cnt, .debug_o
);

//--- rtl/gnn_debug_top.sv
module gnn_debug_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [gnn_debug_pkg::NUM_STAGES-1:0]   vld_i,
  input  logic [gnn_debug_pkg::NUM_STAGES-1:0]   rdy_i,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]    wh_addr_i,
  input  logic [gnn_debug_pkg::PE_DATA_W-1:0]    pe_data_i,
  input  logic                                   pe_strobe_i,
  input  logic                                   feat_ena_i,
  input  logic [gnn_debug_pkg::FEAT_ADDR_W-1:0]  feat_addr_i,
  input  logic                                   clear_i,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]    watch_addr0_i,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]    watch_addr1_i,
  input  gnn_debug_pkg::debug_sel_e              debug_sel_i,
  input  gnn_debug_pkg::stage_e                  stage_sel_i,
  output logic [gnn_debug_pkg::DBG_W-1:0]        debug_o
);

  logic [gnn_debug_pkg::NUM_STAGES-1:0]  vld_q;
  logic [gnn_debug_pkg::NUM_STAGES-1:0]  rdy_q;
  logic [gnn_debug_pkg::NUM_STAGES-1:0]  xfer_q;
  logic [gnn_debug_pkg::NUM_STAGES-1:0]  stall_q;
  logic [gnn_debug_pkg::WH_ADDR_W-1:0]   wh_addr_q;
  logic [gnn_debug_pkg::PE_DATA_W-1:0]   pe_data_q;
  logic                                  pe_strobe_q;
  logic                                  feat_ena_q;
  logic [gnn_debug_pkg::FEAT_ADDR_W-1:0] feat_addr_q;
  logic                                  clr_q;

  logic [gnn_debug_pkg::NUM_STAGES-1:0]                          seen_vld;
  logic [gnn_debug_pkg::NUM_STAGES-1:0]                          seen_rdy;
  logic [gnn_debug_pkg::NUM_STAGES-1:0][gnn_debug_pkg::CNT_W-1:0] xfer_cnt;
  logic [gnn_debug_pkg::NUM_STAGES-1:0][gnn_debug_pkg::CNT_W-1:0] stall_cnt;
  logic [gnn_debug_pkg::PE_DATA_W-1:0]                           watch0;
  logic [gnn_debug_pkg::PE_DATA_W-1:0]                           watch1;
  logic                                                          feat_seen;
  logic                                                          feat_over;

  probe_capture u_capture (
    .clk, .rst_n, .vld_i, .rdy_i, .wh_addr_i, .pe_data_i, .pe_strobe_i,
    .feat_ena_i, .feat_addr_i, .clear_i,
    .vld_o(vld_q), .rdy_o(rdy_q), .xfer_o(xfer_q), .stall_o(stall_q),
    .wh_addr_o(wh_addr_q), .pe_data_o(pe_data_q), .pe_strobe_o(pe_strobe_q),
    .feat_ena_o(feat_ena_q), .feat_addr_o(feat_addr_q), .clear_o(clr_q)
  );

  // one monitor per stage, indexed in stage_e order
  for (genvar g = 0; g < gnn_debug_pkg::NUM_STAGES; g++) begin : g_stage
    stage_monitor u_mon (
      .clk, .rst_n,
      .vld_i(vld_q[g]), .rdy_i(rdy_q[g]), .xfer_i(xfer_q[g]), .stall_i(stall_q[g]),
      .clear_i(clr_q),
      .seen_vld_o(seen_vld[g]), .seen_rdy_o(seen_rdy[g]),
      .xfer_cnt_o(xfer_cnt[g]), .stall_cnt_o(stall_cnt[g])
    );
  end

  addr_watch u_watch (
    .clk, .rst_n,
    .wh_addr_i(wh_addr_q), .pe_data_i(pe_data_q), .pe_strobe_i(pe_strobe_q),
    .watch_addr0_i, .watch_addr1_i,  // software regs, not pipelined
    .feat_ena_i(feat_ena_q), .feat_addr_i(feat_addr_q), .clear_i(clr_q),
    .watch0_o(watch0), .watch1_o(watch1),
    .feat_seen_o(feat_seen), .feat_over_o(feat_over)
  );

  debug_readout u_readout (
    .clk, .rst_n, .debug_sel_i, .stage_sel_i,
    .seen_vld_i(seen_vld), .seen_rdy_i(seen_rdy),
    .xfer_cnt_i(xfer_cnt), .stall_cnt_i(stall_cnt),
    .watch0_i(watch0), .watch1_i(watch1),
    .feat_seen_i(feat_seen), .feat_over_i(feat_over),
    .debug_o
  );

endmodule

//--- rtl/debug_readout.sv
module debug_readout (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  gnn_debug_pkg::debug_sel_e                                     debug_sel_i,
  input  gnn_debug_pkg::stage_e                                         stage_sel_i,
  input  logic [gnn_debug_pkg::NUM_STAGES-1:0]                          seen_vld_i,
  input  logic [gnn_debug_pkg::NUM_STAGES-1:0]                          seen_rdy_i,
  input  logic [gnn_debug_pkg::NUM_STAGES-1:0][gnn_debug_pkg::CNT_W-1:0] xfer_cnt_i,
  input  logic [gnn_debug_pkg::NUM_STAGES-1:0][gnn_debug_pkg::CNT_W-1:0] stall_cnt_i,
  input  logic [gnn_debug_pkg::PE_DATA_W-1:0]                           watch0_i,
  input  logic [gnn_debug_pkg::PE_DATA_W-1:0]                           watch1_i,
  input  logic                                                          feat_seen_i,
  input  logic                                                          feat_over_i,
  output logic [gnn_debug_pkg::DBG_W-1:0]                               debug_o
);

  logic [gnn_debug_pkg::DBG_W-1:0] flags_word;
  logic [gnn_debug_pkg::DBG_W-1:0] sel_word;

  // spmm pair in bits 7:6 down to aggr pair in bits 1:0
  always_comb begin
    flags_word = '0;
    for (int s = 0; s < gnn_debug_pkg::NUM_STAGES; s++) begin
      flags_word[7-2*s] = seen_vld_i[s];
      flags_word[6-2*s] = seen_rdy_i[s];
    end
  end

  always_comb begin
    case (debug_sel_i)
      gnn_debug_pkg::SEL_FLAGS:
        sel_word = flags_word;
      gnn_debug_pkg::SEL_XFER_CNT:
        sel_word = gnn_debug_pkg::DBG_W'(xfer_cnt_i[stage_sel_i]);
      gnn_debug_pkg::SEL_STALL_CNT:
        sel_word = gnn_debug_pkg::DBG_W'(stall_cnt_i[stage_sel_i]);
      gnn_debug_pkg::SEL_WATCH0:
        sel_word = gnn_debug_pkg::DBG_W'(watch0_i);
      gnn_debug_pkg::SEL_WATCH1:
        sel_word = gnn_debug_pkg::DBG_W'(watch1_i);
      gnn_debug_pkg::SEL_FEAT_FLAGS:
        sel_word = {{(gnn_debug_pkg::DBG_W-2){1'b0}}, feat_over_i, feat_seen_i};
      gnn_debug_pkg::SEL_BUILD_ID:
        sel_word = gnn_debug_pkg::DBG_W'(gnn_debug_pkg::NUM_SPARSE_DATA);
      default:
        sel_word = '0;  // spare opcode
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      debug_o <= '0;
    else
      debug_o <= sel_word;
  end

endmodule

//--- rtl/addr_watch.sv
module addr_watch (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]    wh_addr_i,
  input  logic [gnn_debug_pkg::PE_DATA_W-1:0]    pe_data_i,
  input  logic                                   pe_strobe_i,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]    watch_addr0_i,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]    watch_addr1_i,
  input  logic                                   feat_ena_i,
  input  logic [gnn_debug_pkg::FEAT_ADDR_W-1:0]  feat_addr_i,
  input  logic                                   clear_i,
  output logic [gnn_debug_pkg::PE_DATA_W-1:0]    watch0_o,
  output logic [gnn_debug_pkg::PE_DATA_W-1:0]    watch1_o,
  output logic                                   feat_seen_o,
  output logic                                   feat_over_o
);

  logic hit0;
  logic hit1;
  logic over_lim;

  assign hit0     = pe_strobe_i && (wh_addr_i == watch_addr0_i);
  assign hit1     = pe_strobe_i && (wh_addr_i == watch_addr1_i);
  assign over_lim = (feat_addr_i >= gnn_debug_pkg::FEAT_ADDR_LIMIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      watch0_o    <= '0;
      watch1_o    <= '0;
      feat_seen_o <= 1'b0;
      feat_over_o <= 1'b0;
    end else if (clear_i) begin
      watch0_o    <= '0;
      watch1_o    <= '0;
      feat_seen_o <= 1'b0;
      feat_over_o <= 1'b0;
    end else begin
      if (hit0)
        watch0_o <= pe_data_i;
      if (hit1)
        watch1_o <= pe_data_i; // both slots load if addresses are equal
      if (feat_ena_i)
        feat_seen_o <= 1'b1;
      if (feat_ena_i && over_lim)
        feat_over_o <= 1'b1;
    end
  end

endmodule

//--- rtl/stage_monitor.sv
module stage_monitor (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              vld_i,
  input  logic                              rdy_i,
  input  logic                              xfer_i,
  input  logic                              stall_i,
  input  logic                              clear_i,
  output logic                              seen_vld_o,
  output logic                              seen_rdy_o,
  output logic [gnn_debug_pkg::CNT_W-1:0]   xfer_cnt_o,
  output logic [gnn_debug_pkg::CNT_W-1:0]   stall_cnt_o
);

  logic xfer_max;
  logic stall_max;

  assign xfer_max  = &xfer_cnt_o;
  assign stall_max = &stall_cnt_o;

  // sticky flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_vld_o <= 1'b0;
      seen_rdy_o <= 1'b0;
    end else if (clear_i) begin
      seen_vld_o <= 1'b0;
      seen_rdy_o <= 1'b0;
    end else begin
      seen_vld_o <= seen_vld_o | vld_i;
      seen_rdy_o <= seen_rdy_o | rdy_i;
    end
  end

  // counters hold at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      xfer_cnt_o  <= '0;
      stall_cnt_o <= '0;
    end else if (clear_i) begin  // clear beats a same-cycle event
      xfer_cnt_o  <= '0;
      stall_cnt_o <= '0;
    end else begin
      if (xfer_i && !xfer_max)
        xfer_cnt_o <= xfer_cnt_o + 1'b1;
      if (stall_i && !stall_max)
        stall_cnt_o <= stall_cnt_o + 1'b1;
    end
  end

endmodule

//--- rtl/probe_capture.sv
module probe_capture (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [gnn_debug_pkg::NUM_STAGES-1:0]   vld_i,
  input  logic [gnn_debug_pkg::NUM_STAGES-1:0]   rdy_i,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]    wh_addr_i,
  input  logic [gnn_debug_pkg::PE_DATA_W-1:0]    pe_data_i,
  input  logic                                   pe_strobe_i,
  input  logic                                   feat_ena_i,
  input  logic [gnn_debug_pkg::FEAT_ADDR_W-1:0]  feat_addr_i,
  input  logic                                   clear_i,
  output logic [gnn_debug_pkg::NUM_STAGES-1:0]   vld_o,
  output logic [gnn_debug_pkg::NUM_STAGES-1:0]   rdy_o,
  output logic [gnn_debug_pkg::NUM_STAGES-1:0]   xfer_o,
  output logic [gnn_debug_pkg::NUM_STAGES-1:0]   stall_o,
  output logic [gnn_debug_pkg::WH_ADDR_W-1:0]    wh_addr_o,
  output logic [gnn_debug_pkg::PE_DATA_W-1:0]    pe_data_o,
  output logic                                   pe_strobe_o,
  output logic                                   feat_ena_o,
  output logic [gnn_debug_pkg::FEAT_ADDR_W-1:0]  feat_addr_o,
  output logic                                   clear_o
);

  // one flop on every probe, the accelerator sits far away
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_o       <= '0;
      rdy_o       <= '0;
      wh_addr_o   <= '0;
      pe_data_o   <= '0;
      pe_strobe_o <= 1'b0;
      feat_ena_o  <= 1'b0;
      feat_addr_o <= '0;
      clear_o     <= 1'b0;
    end else begin
      vld_o       <= vld_i;
      rdy_o       <= rdy_i;
      wh_addr_o   <= wh_addr_i;
      pe_data_o   <= pe_data_i;
      pe_strobe_o <= pe_strobe_i;
      feat_ena_o  <= feat_ena_i;
      feat_addr_o <= feat_addr_i;
      clear_o     <= clear_i;
    end
  end

  assign xfer_o  = vld_o & rdy_o;  // from registered levels
  assign stall_o = vld_o & ~rdy_o;

endmodule

//--- rtl/gnn_debug_pkg.sv
package gnn_debug_pkg;

  localparam int NUM_STAGES = 4;
  localparam int CNT_W      = 32;
  localparam int DBG_W      = 32;

  // accelerator buffer port widths
  localparam int WH_ADDR_W   = 14;
  localparam int PE_DATA_W   = 12;
  localparam int FEAT_ADDR_W = 16;

  localparam logic [FEAT_ADDR_W-1:0] FEAT_ADDR_LIMIT = 16'd43328; // first illegal address

  localparam int NUM_SPARSE_DATA = 12; // build id

  typedef enum logic [1:0] {
    STAGE_SPMM = 2'd0,
    STAGE_DMVM = 2'd1,
    STAGE_SM   = 2'd2,
    STAGE_AGGR = 2'd3
  } stage_e;

  typedef enum logic [2:0] {
    SEL_FLAGS      = 3'd0,
    SEL_XFER_CNT   = 3'd1,
    SEL_STALL_CNT  = 3'd2,
    SEL_WATCH0     = 3'd3,
    SEL_WATCH1     = 3'd4,
    SEL_FEAT_FLAGS = 3'd5,
    SEL_BUILD_ID   = 3'd6
  } debug_sel_e;

endpackage
